// File: axi_sys.f
hw/axi_pkg.sv
hw/cpu_pkg.sv
hw/axi_master.sv
hw/axi_arbiter.sv
hw/axi_sram_slave.sv
hw/axi_sys_top.sv
test/axi_sys_tb.sv

// File: Makefile
TOP := axi_sys_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f axi_sys.f \
		--Mdir obj_dir -o $(TOP)
	out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^No errors$$"

clean:
	rm -rf obj_dir

// File: test/axi_sys_tb.sv
module axi_sys_tb;
  import axi_pkg::*;
  import cpu_pkg::*;

  localparam int n_fill = sram_words;
  localparam int n_part = 64;
  localparam int n_rounds = 32;
  localparam int n_mix = 100;
  localparam int total_accesses = 2 * n_fill + 2 * n_part + 4 * n_rounds + 2 * n_mix;
  localparam int timeout_cycles = 64 * total_accesses;

  logic         clk = 1'b0;
  logic         rstn;
  logic         i_access_request;
  logic         i_write;
  access_size_t i_size;
  data_t        i_data_in;
  addr_t        i_addr;
  data_t        i_data_out;
  logic         i_stall;
  logic         d_access_request;
  logic         d_write;
  access_size_t d_size;
  data_t        d_data_in;
  addr_t        d_addr;
  data_t        d_data_out;
  logic         d_stall;

  integer       seed = 32'h700f_70de;
  int           errors = 0;
  int           checks = 0;
  int           errors_at_start = 0;
  int           cycles = 0;
  data_t        model [sram_words];
  data_t        last_read [2];

  // Pre-generated mix so both ports draw from the seed in a fixed order
  logic         op_wr [2][n_mix];
  access_size_t op_size [2][n_mix];
  addr_t        op_addr [2][n_mix];
  data_t        op_data [2][n_mix];
  int           op_gap [2][n_mix];

  axi_sys_top uut (.*);

  initial begin
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > timeout_cycles) begin
      $display("Timeout: accesses still pending after %0d cycles", cycles);
      $display("Errors found");
      $finish;
    end
  end

  task automatic check_data(input string name, input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_stall(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  function automatic int word_index(input addr_t a);
    return int'((a >> 2) % sram_words);
  endfunction

  // Byte lanes from the low address bits, half and word aligned down
  function automatic void apply_write(input addr_t a, input access_size_t sz, input data_t d);
    int idx;
    idx = word_index(a);
    case (sz)
      size_byte: model[idx][{a[1:0], 3'b000} +: 8] = d[7:0];
      size_half: model[idx][{a[1], 4'b0000} +: 16] = d[15:0];
      default:   model[idx] = d;
    endcase
  endfunction

  function automatic access_size_t random_size();
    logic [31:0] v;
    v = $random(seed);
    case (v % 3)
      0:       return size_byte;
      1:       return size_half;
      default: return size_word;
    endcase
  endfunction

  // Holds the request until stall falls, returns in the completion cycle
  task automatic cpu_access(input bit port, input logic wr, input access_size_t sz,
                            input addr_t a, input data_t d, output data_t rd);
    @(negedge clk);
    // Idle master shows the last read word
    check_data(port ? "d_data_out" : "i_data_out", port ? d_data_out : i_data_out,
               last_read[port]);
    if (port) begin
      d_write = wr;
      d_size = sz;
      d_addr = a;
      d_data_in = d;
      d_access_request = 1'b1;
    end else begin
      i_write = wr;
      i_size = sz;
      i_addr = a;
      i_data_in = d;
      i_access_request = 1'b1;
    end
    @(negedge clk);
    check_stall(port ? "d_stall" : "i_stall", port ? d_stall : i_stall, 1'b1);
    while (port ? d_stall : i_stall) begin
      @(negedge clk);
    end
    rd = port ? d_data_out : i_data_out;
    if (port) begin
      d_access_request = 1'b0;
    end else begin
      i_access_request = 1'b0;
    end
  endtask

  task automatic run_one(input bit port, input logic wr, input access_size_t sz,
                         input addr_t a, input data_t d);
    data_t rd;
    cpu_access(port, wr, sz, a, d, rd);
    if (wr) begin
      apply_write(a, sz, d);
    end else begin
      check_data(port ? "d_data_out" : "i_data_out", rd, model[word_index(a)]);
      last_read[port] = model[word_index(a)];
    end
  endtask

  // Address bit 9 picks the memory half, so the ports never share a word
  task automatic gen_mix();
    logic [31:0] v;
    for (int p = 0; p < 2; p++) begin
      for (int k = 0; k < n_mix; k++) begin
        v = $random(seed);
        op_wr[p][k] = v[0];
        op_gap[p][k] = int'(v[3:2]);
        op_size[p][k] = random_size();
        op_addr[p][k] = $random(seed);
        op_addr[p][k][9] = p[0];
        op_data[p][k] = $random(seed);
      end
    end
  endtask

  task automatic run_mix(input bit port);
    for (int k = 0; k < n_mix; k++) begin
      repeat (op_gap[port][k]) @(negedge clk);
      run_one(port, op_wr[port][k], op_size[port][k], op_addr[port][k], op_data[port][k]);
    end
  endtask

  task automatic report_test(input string name);
    int n;
    n = errors - errors_at_start;
    if (n == 0) begin
      $display("%s: pass", name);
    end else begin
      $display("%s: fail, %0d mismatches", name, n);
    end
    errors_at_start = errors;
  endtask

  initial begin
    addr_t        a;
    addr_t        ai;
    addr_t        ad;
    data_t        di;
    data_t        dd;
    logic [31:0]  v;
    access_size_t sz;

    for (int i = 0; i < sram_words; i++) begin
      model[i] = '0;
    end
    last_read[0] = '0;
    last_read[1] = '0;
    rstn = 1'b0;
    i_access_request = 1'b0;
    i_write = 1'b0;
    i_size = size_word;
    i_data_in = '0;
    i_addr = '0;
    d_access_request = 1'b0;
    d_write = 1'b0;
    d_size = size_word;
    d_data_in = '0;
    d_addr = '0;
    repeat (5) @(negedge clk);
    rstn = 1'b1;

    @(negedge clk);
    check_stall("i_stall", i_stall, 1'b0);
    check_stall("d_stall", d_stall, 1'b0);
    check_data("i_data_out", i_data_out, '0);
    check_data("d_data_out", d_data_out, '0);
    report_test("after reset");

    for (int i = 0; i < n_fill; i++) begin
      run_one(1'b1, 1'b1, size_word, addr_t'(i * 4), data_t'($random(seed)));
    end
    for (int i = 0; i < n_fill; i++) begin
      run_one(1'b1, 1'b0, size_word, addr_t'(i * 4), '0);
    end
    report_test("word write and read-back");

    for (int k = 0; k < n_part; k++) begin
      a = $random(seed);
      v = $random(seed);
      sz = v[0] ? size_half : size_byte;
      run_one(1'b1, 1'b1, sz, a, data_t'($random(seed)));
      run_one(1'b1, 1'b0, size_word, a, '0);
    end
    report_test("byte and half-word writes");

    for (int k = 0; k < n_rounds; k++) begin
      ai = $random(seed);
      ai[9] = 1'b0;
      ad = $random(seed);
      ad[9] = 1'b1;
      di = $random(seed);
      dd = $random(seed);
      fork
        run_one(1'b0, 1'b1, size_word, ai, di);
        run_one(1'b1, 1'b1, size_word, ad, dd);
      join
      fork
        run_one(1'b0, 1'b0, size_word, ai, '0);
        run_one(1'b1, 1'b0, size_word, ad, '0);
      join
    end
    report_test("contention");

    gen_mix();
    fork
      run_mix(1'b0);
      run_mix(1'b1);
    join
    report_test("random mix");

    $display("%0d checks, %0d failed", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: hw/axi_sys_top.sv
module axi_sys_top (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  i_access_request,
  input  logic                  i_write,
  input  cpu_pkg::access_size_t i_size,
  input  axi_pkg::data_t        i_data_in,
  input  axi_pkg::addr_t        i_addr,
  output axi_pkg::data_t        i_data_out,
  output logic                  i_stall,
  input  logic                  d_access_request,
  input  logic                  d_write,
  input  cpu_pkg::access_size_t d_size,
  input  axi_pkg::data_t        d_data_in,
  input  axi_pkg::addr_t        d_addr,
  output axi_pkg::data_t        d_data_out,
  output logic                  d_stall
);
  import axi_pkg::*;

  axi_req_t m_req [2];
  axi_rsp_t m_rsp [2];
  axi_req_t s_req;
  axi_rsp_t s_rsp;

  // Slot 0 is the instruction port, first in line after reset
  axi_master imaster (
    .clk            (clk),
    .rstn           (rstn),
    .access_request (i_access_request),
    .write          (i_write),
    .size           (i_size),
    .data_in        (i_data_in),
    .addr           (i_addr),
    .data_out       (i_data_out),
    .stall          (i_stall),
    .bus_req        (m_req[0]),
    .bus_rsp        (m_rsp[0])
  );

  axi_master dmaster (
    .clk            (clk),
    .rstn           (rstn),
    .access_request (d_access_request),
    .write          (d_write),
    .size           (d_size),
    .data_in        (d_data_in),
    .addr           (d_addr),
    .data_out       (d_data_out),
    .stall          (d_stall),
    .bus_req        (m_req[1]),
    .bus_rsp        (m_rsp[1])
  );

  axi_arbiter arbiter (
    .clk   (clk),
    .rstn  (rstn),
    .m_req (m_req),
    .m_rsp (m_rsp),
    .s_req (s_req),
    .s_rsp (s_rsp)
  );

  axi_sram_slave sram (
    .clk     (clk),
    .rstn    (rstn),
    .bus_req (s_req),
    .bus_rsp (s_rsp)
  );

endmodule

// File: hw/axi_sram_slave.sv
module axi_sram_slave (
  input  logic              clk,
  input  logic              rstn,
  input  axi_pkg::axi_req_t bus_req,
  output axi_pkg::axi_rsp_t bus_rsp
);
  import axi_pkg::*;
  import cpu_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_wdata,
    st_bresp,
    st_rresp
  } slave_state_t;

  slave_state_t                    state;
  data_t                           mem [sram_words];
  logic [$clog2(sram_words)-1:0]   widx_r;
  data_t                           rdata_r;
  logic                            id_r;
  logic                            aw_hs;
  logic                            w_hs;
  logic                            b_hs;
  logic                            ar_hs;
  logic                            r_hs;

  // A pending write wins over a read in idle
  assign aw_hs = (state == st_idle) & bus_req.aw_valid;
  assign ar_hs = (state == st_idle) & ~bus_req.aw_valid & bus_req.ar_valid;
  assign w_hs  = (state == st_wdata) & bus_req.w_valid;
  assign b_hs  = (state == st_bresp) & bus_req.b_ready;
  assign r_hs  = (state == st_rresp) & bus_req.r_ready;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (aw_hs) begin
            state <= st_wdata;
          end else if (ar_hs) begin
            state <= st_rresp;
          end
        end
        st_wdata: if (w_hs) state <= st_bresp;
        st_bresp: if (b_hs) state <= st_idle;
        st_rresp: if (r_hs) state <= st_idle;
        default:  state <= st_idle;
      endcase
    end
  end

  // Word index wraps at the memory depth
  always_ff @(posedge clk) begin
    if (aw_hs) begin
      widx_r <= bus_req.aw.addr[2 +: $clog2(sram_words)];
      id_r   <= bus_req.aw.id;
    end
    if (ar_hs) begin
      rdata_r <= mem[bus_req.ar.addr[2 +: $clog2(sram_words)]];
      id_r    <= bus_req.ar.id;
    end
    if (w_hs) begin
      for (int k = 0; k < strb_bits; k++) begin
        if (bus_req.w.strb[k]) begin
          mem[widx_r][8*k +: 8] <= bus_req.w.data[8*k +: 8];
        end
      end
    end
  end

  always_comb begin
    bus_rsp = '0;
    bus_rsp.aw_ready = (state == st_idle);
    bus_rsp.ar_ready = (state == st_idle) & ~bus_req.aw_valid;
    bus_rsp.w_ready  = (state == st_wdata);
    bus_rsp.b.id     = id_r;
    bus_rsp.b.resp   = resp_okay;
    bus_rsp.b_valid  = (state == st_bresp);
    bus_rsp.r.id     = id_r;
    bus_rsp.r.data   = rdata_r;
    bus_rsp.r.resp   = resp_okay;
    bus_rsp.r.last   = 1'b1;
    bus_rsp.r_valid  = (state == st_rresp);
  end

  rsp_exclusive: assert property (@(posedge clk) disable iff (!rstn)
    !(bus_rsp.r_valid && bus_rsp.b_valid));

endmodule

// File: hw/axi_arbiter.sv
module axi_arbiter (
  input  logic              clk,
  input  logic              rstn,
  input  axi_pkg::axi_req_t m_req [2],
  output axi_pkg::axi_rsp_t m_rsp [2],
  output axi_pkg::axi_req_t s_req,
  input  axi_pkg::axi_rsp_t s_rsp
);
  import axi_pkg::*;

  logic       locked;
  logic       grant;
  logic       rr_ptr;
  logic       sel;
  logic [1:0] req_any;
  logic       release_grant;

  assign req_any[0] = m_req[0].aw_valid | m_req[0].ar_valid;
  assign req_any[1] = m_req[1].aw_valid | m_req[1].ar_valid;

  // Pointer side first, the other one if it is quiet
  assign sel = req_any[rr_ptr] ? rr_ptr : ~rr_ptr;

  assign release_grant = locked &
                         ((s_rsp.b_valid & m_req[grant].b_ready) |
                          (s_rsp.r_valid & m_req[grant].r_ready));

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      locked <= 1'b0;
      grant  <= 1'b0;
      rr_ptr <= 1'b0;
    end else if (!locked) begin
      if (|req_any) begin
        locked <= 1'b1;
        grant  <= sel;
      end
    end else if (release_grant) begin
      locked <= 1'b0;
      rr_ptr <= ~grant;
    end
  end

  always_comb begin
    s_req = '0;
    if (locked) begin
      s_req       = m_req[grant];
      s_req.aw.id = grant;
      s_req.ar.id = grant;
    end
  end

  // Readies only to the granted side, responses steered by ID
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      m_rsp[i]   = '0;
      m_rsp[i].b = s_rsp.b;
      m_rsp[i].r = s_rsp.r;
      if (locked && grant == i[0]) begin
        m_rsp[i].aw_ready = s_rsp.aw_ready;
        m_rsp[i].w_ready  = s_rsp.w_ready;
        m_rsp[i].ar_ready = s_rsp.ar_ready;
      end
      m_rsp[i].b_valid = s_rsp.b_valid && s_rsp.b.id == i[0];
      m_rsp[i].r_valid = s_rsp.r_valid && s_rsp.r.id == i[0];
    end
  end

  grant_held: assert property (@(posedge clk) disable iff (!rstn)
    locked && !release_grant |=> locked && $stable(grant));

  b_id_match: assert property (@(posedge clk) disable iff (!rstn)
    s_rsp.b_valid |-> locked && s_rsp.b.id == grant);

  r_id_match: assert property (@(posedge clk) disable iff (!rstn)
    s_rsp.r_valid |-> locked && s_rsp.r.id == grant);

endmodule

// File: hw/axi_master.sv
module axi_master (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  access_request,
  input  logic                  write,
  input  cpu_pkg::access_size_t size,
  input  axi_pkg::data_t        data_in,
  input  axi_pkg::addr_t        addr,
  output axi_pkg::data_t        data_out,
  output logic                  stall,
  output axi_pkg::axi_req_t     bus_req,
  input  axi_pkg::axi_rsp_t     bus_rsp
);
  import axi_pkg::*;
  import cpu_pkg::*;

  master_state_t state;
  master_state_t state_next;
  addr_t         addr_r;
  data_t         wdata_r;
  strb_t         wstrb_r;
  access_size_t  size_r;
  data_t         rdata_r;
  logic [1:0]    lane;
  data_t         wdata_lanes;
  strb_t         wstrb_lanes;
  logic          start;
  logic          aw_hs;
  logic          w_hs;
  logic          b_hs;
  logic          ar_hs;
  logic          r_hs;

  // Handshakes taken from state bits, not from bus_req
  assign aw_hs = state[aw_bit] & bus_rsp.aw_ready;
  assign w_hs  = (state[w_bit] | aw_hs) & bus_rsp.w_ready;
  assign b_hs  = (state[w_bit] | state[b_bit]) & bus_rsp.b_valid;
  assign ar_hs = state[ar_bit] & bus_rsp.ar_ready;
  assign r_hs  = state[r_bit] & bus_rsp.r_valid;

  assign start = state[idle_bit] & access_request;

  // Access done in the R or B handshake cycle
  assign stall = access_request & ~(r_hs | b_hs);

  assign data_out = r_hs ? bus_rsp.r.data : rdata_r;

  // Lane placement, misaligned accesses rounded down
  always_comb begin
    case (size)
      size_byte: begin
        lane        = addr[1:0];
        wdata_lanes = {(strb_bits){data_in[7:0]}};
        wstrb_lanes = strb_t'(1) << addr[1:0];
      end
      size_half: begin
        lane        = {addr[1], 1'b0};
        wdata_lanes = {(strb_bits / 2){data_in[15:0]}};
        wstrb_lanes = strb_t'(3) << {addr[1], 1'b0};
      end
      default: begin
        lane        = 2'b00;
        wdata_lanes = data_in;
        wstrb_lanes = '1;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (start) begin
      addr_r  <= {addr[addr_bits-1:2], lane};
      wdata_r <= wdata_lanes;
      wstrb_r <= wstrb_lanes;
      size_r  <= size;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rdata_r <= '0;
    end else if (r_hs) begin
      rdata_r <= bus_rsp.r.data;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = idle;
    case (1'b1)
      state[idle_bit]: state_next = !access_request ? idle : (write ? aw : ar);
      state[ar_bit]:   state_next = ar_hs ? r : ar;
      state[r_bit]:    state_next = r_hs ? idle : r;
      state[aw_bit]:   state_next = aw_hs ? (w_hs ? b : w) : aw;
      state[w_bit]:    state_next = w_hs ? (b_hs ? idle : b) : w;
      state[b_bit]:    state_next = b_hs ? idle : b;
      default:         state_next = idle;
    endcase
  end

  always_comb begin
    bus_req = '0;
    bus_req.aw.addr  = addr_r;
    bus_req.aw.len   = '0;
    bus_req.aw.size  = size_t'(size_r);
    bus_req.aw.burst = burst_incr;
    bus_req.w.data   = wdata_r;
    bus_req.w.strb   = wstrb_r;
    bus_req.w.last   = 1'b1;
    bus_req.ar.addr  = addr_r;
    bus_req.ar.len   = '0;
    bus_req.ar.size  = size_t'(size_r);
    bus_req.ar.burst = burst_incr;
    bus_req.aw_valid = state[aw_bit];
    // W may go out together with the AW handshake
    bus_req.w_valid  = state[w_bit] | aw_hs;
    bus_req.b_ready  = state[w_bit] | state[b_bit];
    bus_req.ar_valid = state[ar_bit];
    bus_req.r_ready  = state[r_bit];
  end

  state_onehot: assert property (@(posedge clk) disable iff (!rstn) $onehot(state));

  aw_valid_held: assert property (@(posedge clk) disable iff (!rstn)
    bus_req.aw_valid && !bus_rsp.aw_ready |=> bus_req.aw_valid);

  ar_valid_held: assert property (@(posedge clk) disable iff (!rstn)
    bus_req.ar_valid && !bus_rsp.ar_ready |=> bus_req.ar_valid);

endmodule

// File: hw/cpu_pkg.sv
package cpu_pkg;

  // Values line up with the AXI size encoding
  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } access_size_t;

  localparam int idle_bit = 0;
  localparam int ar_bit = 1;
  localparam int r_bit = 2;
  localparam int aw_bit = 3;
  localparam int w_bit = 4;
  localparam int b_bit = 5;

  // One-hot master states
  typedef enum logic [5:0] {
    idle = 6'b1 << idle_bit,
    ar   = 6'b1 << ar_bit,
    r    = 6'b1 << r_bit,
    aw   = 6'b1 << aw_bit,
    w    = 6'b1 << w_bit,
    b    = 6'b1 << b_bit
  } master_state_t;

  localparam int sram_words = 256;

endpackage

// File: hw/axi_pkg.sv
package axi_pkg;

  localparam int addr_bits = 32;
  localparam int data_bits = 32;
  localparam int strb_bits = data_bits / 8;
  localparam int len_bits = 8;
  localparam int size_bits = 3;
  localparam int burst_bits = 2;
  localparam int resp_bits = 2;

  typedef logic [addr_bits-1:0] addr_t;
  typedef logic [data_bits-1:0] data_t;
  typedef logic [strb_bits-1:0] strb_t;
  typedef logic [len_bits-1:0] len_t;
  typedef logic [size_bits-1:0] size_t;
  typedef logic [burst_bits-1:0] burst_t;
  typedef logic [resp_bits-1:0] resp_t;

  localparam burst_t burst_incr = 2'b01;
  localparam resp_t resp_okay = 2'b00;

  // Address channels share one layout
  typedef struct packed {
    logic   id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
  } axi_ar_t;

  typedef struct packed {
    logic   id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
  } axi_aw_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } axi_w_t;

  typedef struct packed {
    logic  id;
    resp_t resp;
  } axi_b_t;

  typedef struct packed {
    logic  id;
    data_t data;
    resp_t resp;
    logic  last;
  } axi_r_t;

  // Master to slave
  typedef struct packed {
    axi_aw_t aw;
    logic    aw_valid;
    axi_w_t  w;
    logic    w_valid;
    logic    b_ready;
    axi_ar_t ar;
    logic    ar_valid;
    logic    r_ready;
  } axi_req_t;

  // Slave to master
  typedef struct packed {
    logic   aw_ready;
    logic   w_ready;
    axi_b_t b;
    logic   b_valid;
    logic   ar_ready;
    axi_r_t r;
    logic   r_valid;
  } axi_rsp_t;

endpackage
